// File: buf_map_pkg.sv
package buf_map_pkg;

    typedef logic [10:0] addr_t;      // display RAM address
    typedef logic [15:0] data_t;      // one display sample

    localparam int REGION_WORDS = 256;
    localparam int NUM_SRC      = 4;

    typedef logic [$clog2(REGION_WORDS)-1:0] word_idx_t;

    // write order, id doubles as region number
    typedef enum logic [1:0] {
        SRC_HSST_FREQ = 2'd0,
        SRC_AD_FREQ   = 2'd1,
        SRC_HSST_TIME = 2'd2,
        SRC_AD_TIME   = 2'd3
    } src_id_t;

    typedef struct packed {
        logic  full;
        data_t rddata;
    } src_fifo_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
        data_t data;
    } dram_wr_t;

    // word 0 of the RAM is never used
    function automatic addr_t region_first(src_id_t region);
        return addr_t'(int'(region) * REGION_WORDS + 1);
    endfunction

    function automatic addr_t region_last(src_id_t region);
        return addr_t'((int'(region) + 1) * REGION_WORDS);
    endfunction

endpackage

// File: capture_writer.sv
`timescale 1ns/1ps

module capture_writer
    import buf_map_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  src_fifo_t          src_fifo [NUM_SRC],
    output logic [NUM_SRC-1:0] rden,
    output dram_wr_t           dram_wr
);

    typedef enum logic {
        ST_WAIT,
        ST_COPY
    } wr_state_t;

    wr_state_t state;
    src_id_t   cur_src;
    src_id_t   next_src;
    word_idx_t word_cnt;
    logic      rd_active;     // read strobe for cur_src
    logic      last_rd;
    logic      wr_en;
    addr_t     wr_addr;
    addr_t     region_base;

    assign region_base = region_first(cur_src);
    assign next_src    = src_id_t'(cur_src + 2'd1);   // 3 wraps to 0
    assign last_rd     = (word_cnt == word_idx_t'(REGION_WORDS - 1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= ST_WAIT;
            cur_src   <= SRC_HSST_FREQ;
            word_cnt  <= '0;
            rd_active <= 1'b0;
        end
        else
        begin
            case (state)
                ST_WAIT:
                begin
                    if (src_fifo[cur_src].full)
                    begin
                        state     <= ST_COPY;
                        rd_active <= 1'b1;
                        word_cnt  <= '0;
                    end
                end
                ST_COPY:
                begin
                    if (rd_active)
                    begin
                        word_cnt <= word_cnt + 1'b1;
                        if (last_rd)
                            rd_active <= 1'b0;
                    end
                    else if (wr_en)
                    begin
                        // final word goes out this cycle
                        state   <= ST_WAIT;
                        cur_src <= next_src;
                    end
                end
                default:
                    state <= ST_WAIT;
            endcase
        end
    end

    // write trails the read strobe by the fifo latency
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_en   <= 1'b0;
            wr_addr <= '0;
        end
        else
        begin
            wr_en <= rd_active;
            if (rd_active)
                wr_addr <= region_base + addr_t'(word_cnt);
        end
    end

    always_comb
    begin
        rden = '0;
        if (rd_active)
            rden[cur_src] = 1'b1;
    end

    assign dram_wr.en   = wr_en;
    assign dram_wr.addr = wr_addr;
    assign dram_wr.data = wr_en ? src_fifo[cur_src].rddata : '0;  // fifo word is live now

endmodule

// File: disp_pkg.sv
package disp_pkg;

    import buf_map_pkg::*;

    typedef logic [11:0] row_t;       // active row number

    localparam row_t ROW_SPLIT = 12'd359;   // last row of upper half
    localparam row_t ROW_LAST  = 12'd719;

    typedef enum logic [1:0] {
        VIEW_HSST = 2'd0,   // hsst freq over hsst time
        VIEW_AD   = 2'd1,   // ad freq over ad time
        VIEW_TIME = 2'd2,   // both time records
        VIEW_FREQ = 2'd3    // both freq records
    } view_mode_t;

    localparam int NUM_VIEWS = 4;

    // indexed by view_mode_t
    localparam src_id_t VIEW_TOP_REGION [NUM_VIEWS] = '{
        SRC_HSST_FREQ,
        SRC_AD_FREQ,
        SRC_HSST_TIME,
        SRC_HSST_FREQ
    };

    localparam src_id_t VIEW_BOT_REGION [NUM_VIEWS] = '{
        SRC_HSST_TIME,
        SRC_AD_TIME,
        SRC_AD_TIME,
        SRC_AD_FREQ
    };

endpackage

// File: files.f
buf_map_pkg.sv
disp_pkg.sv
capture_writer.sv
view_select.sv
scan_addr_gen.sv
scope_frame_buf_ctrl.sv
scope_frame_buf_props.sv
tb_scope_frame_buf_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_scope_frame_buf_ctrl -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/Vtb_scope_frame_buf_ctrl 2>&1)"
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1

// File: scan_addr_gen.sv
`timescale 1ns/1ps

module scan_addr_gen
    import buf_map_pkg::*;
    import disp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  view_mode_t view_mode,
    input  logic       view_changed,
    input  logic       de,
    input  logic       point_done,
    input  row_t       act_y,
    output addr_t      rd_addr
);

    src_id_t top_region;
    src_id_t bot_region;
    addr_t   top_first;
    addr_t   top_last;
    addr_t   bot_first;
    addr_t   bot_last;
    logic    at_top_last;
    logic    at_bot_last;

    assign top_region = VIEW_TOP_REGION[view_mode];
    assign bot_region = VIEW_BOT_REGION[view_mode];

    assign top_first = region_first(top_region);
    assign top_last  = region_last(top_region);
    assign bot_first = region_first(bot_region);
    assign bot_last  = region_last(bot_region);

    assign at_top_last = (rd_addr == top_last);
    assign at_bot_last = (rd_addr == bot_last);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_addr <= '0;
        end
        else if (view_changed)
        begin
            rd_addr <= top_first;     // restart on new view
        end
        else if (point_done)
        begin
            if (at_bot_last && act_y == ROW_LAST)
                rd_addr <= top_first;   // end of frame
            else if (at_bot_last && act_y > ROW_SPLIT)
                rd_addr <= bot_first;
            else if (at_top_last && act_y == ROW_SPLIT)
                rd_addr <= bot_first;   // switch to lower half
            else if (at_top_last && act_y < ROW_SPLIT)
                rd_addr <= top_first;
            else if (de)
                rd_addr <= rd_addr + 1'b1;
        end
    end

endmodule

// File: scope_frame_buf_ctrl.sv
`timescale 1ns/1ps

module scope_frame_buf_ctrl
    import buf_map_pkg::*;
    import disp_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  src_fifo_t          src_fifo [NUM_SRC],
    input  logic               key_a,
    input  logic               key_b,
    input  logic               vs,
    input  logic               de,
    input  logic               point_done,
    input  row_t               act_y,
    output logic [NUM_SRC-1:0] rden,
    output dram_wr_t           dram_wr,
    output addr_t              rd_addr,
    output view_mode_t         view_mode
);

    logic view_changed;

    // write side, free running
    capture_writer u_writer (
        .clk      (clk),
        .rst_n    (rst_n),
        .src_fifo (src_fifo),
        .rden     (rden),
        .dram_wr  (dram_wr)
    );

    view_select u_view (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_a        (key_a),
        .key_b        (key_b),
        .vs           (vs),
        .view_mode    (view_mode),
        .view_changed (view_changed)
    );

    scan_addr_gen u_scan (
        .clk          (clk),
        .rst_n        (rst_n),
        .view_mode    (view_mode),
        .view_changed (view_changed),
        .de           (de),
        .point_done   (point_done),
        .act_y        (act_y),
        .rd_addr      (rd_addr)
    );

endmodule

// File: scope_frame_buf_props.sv
`timescale 1ns/1ps

module scope_frame_buf_props
    import buf_map_pkg::*;
    import disp_pkg::*;
(
    input logic               clk,
    input logic               rst_n,
    input logic [NUM_SRC-1:0] rden,
    input dram_wr_t           dram_wr,
    input addr_t              rd_addr,
    input view_mode_t         view_mode
);

    logic       armed;      // set once the first view change landed
    view_mode_t mode_d;
    logic [8:0] run_len;
    int         top_lo;
    int         bot_lo;
    logic       in_top;
    logic       in_bot;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            armed   <= 1'b0;
            mode_d  <= VIEW_HSST;
            run_len <= '0;
        end
        else
        begin
            mode_d  <= view_mode;
            armed   <= armed | (mode_d != view_mode);
            run_len <= (|rden) ? run_len + 9'd1 : 9'd0;
        end
    end

    always_comb
    begin
        top_lo = int'(VIEW_TOP_REGION[mode_d]) * REGION_WORDS + 1;
        bot_lo = int'(VIEW_BOT_REGION[mode_d]) * REGION_WORDS + 1;
        in_top = int'(rd_addr) >= top_lo && int'(rd_addr) < top_lo + REGION_WORDS;
        in_bot = int'(rd_addr) >= bot_lo && int'(rd_addr) < bot_lo + REGION_WORDS;
    end

    a_rden_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(rden))
        else $error("rden has more than one bit set");

    a_rden_max: assert property (@(posedge clk) disable iff (!rst_n)
        (|rden) |-> (int'(run_len) < REGION_WORDS))
        else $error("rden burst longer than a region");

    a_rden_steady: assert property (@(posedge clk) disable iff (!rst_n)
        ((|rden) && run_len != '0) |-> (rden == $past(rden)))
        else $error("rden switched source inside a burst");

    a_rden_len: assert property (@(posedge clk) disable iff (!rst_n)
        (!(|rden) && run_len != '0) |-> (int'(run_len) == REGION_WORDS))
        else $error("rden burst shorter than a region");

    a_wr_range: assert property (@(posedge clk) disable iff (!rst_n)
        dram_wr.en |-> (dram_wr.addr >= 11'd1 && dram_wr.addr <= 11'd1024))
        else $error("write address outside the display RAM");

    a_scan_range: assert property (@(posedge clk) disable iff (!rst_n)
        armed |-> (in_top || in_bot))
        else $error("rd_addr left the regions of the current view");

endmodule

bind scope_frame_buf_ctrl scope_frame_buf_props props0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .rden      (rden),
    .dram_wr   (dram_wr),
    .rd_addr   (rd_addr),
    .view_mode (view_mode)
);

// File: tb_scope_frame_buf_ctrl.sv
`timescale 1ns/1ps

module tb_scope_frame_buf_ctrl
    import buf_map_pkg::*;
    import disp_pkg::*;
;

    localparam int ROW_CYCLES   = REGION_WORDS;   // one region per row
    localparam int BLANK_CYCLES = 10;
    localparam int FRAME_CYCLES = (int'(ROW_LAST) + 1) * ROW_CYCLES + BLANK_CYCLES;
    localparam int NUM_FRAMES   = 6;
    localparam int MIN_BURSTS   = NUM_SRC + 1;
    localparam int WATCHDOG_CYCLES =
        2 * (NUM_FRAMES * FRAME_CYCLES + MIN_BURSTS * (REGION_WORDS + 64)) + 20;

    logic               clk;
    logic               rst_n;
    src_fifo_t          src_fifo [NUM_SRC];
    logic               key_a;
    logic               key_b;
    logic               vs;
    logic               de;
    logic               point_done;
    row_t               act_y;
    logic [NUM_SRC-1:0] rden;
    dram_wr_t           dram_wr;
    addr_t              rd_addr;
    view_mode_t         view_mode;

    integer             seed = 32'h08fa_5731;
    int                 fill_wait [NUM_SRC];
    int                 rd_cnt [NUM_SRC];
    logic [NUM_SRC-1:0] prev_rden;
    int                 wr_src;
    int                 wr_idx;
    int                 burst_cnt;
    view_mode_t         exp_mode;
    view_mode_t         mode_seen;
    logic               scan_on;
    int                 exp_rd;

    scope_frame_buf_ctrl dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .src_fifo   (src_fifo),
        .key_a      (key_a),
        .key_b      (key_b),
        .vs         (vs),
        .de         (de),
        .point_done (point_done),
        .act_y      (act_y),
        .rden       (rden),
        .dram_wr    (dram_wr),
        .rd_addr    (rd_addr),
        .view_mode  (view_mode)
    );

    always #20 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string name, input int got, input int exp);
        if (got != exp)
            stop_with_failure($sformatf("error: time %0t: %s is %0h, expected %0h",
                                        $time, name, got, exp));
    endtask

    // region pairs per view
    function automatic int upper_of(input view_mode_t m);
        case (m)
            VIEW_HSST: return 0;
            VIEW_AD:   return 1;
            VIEW_TIME: return 2;
            default:   return 0;
        endcase
    endfunction

    function automatic int lower_of(input view_mode_t m);
        case (m)
            VIEW_HSST: return 2;
            VIEW_AD:   return 3;
            VIEW_TIME: return 3;
            default:   return 1;
        endcase
    endfunction

    function automatic int first_word(input int region);
        return region * REGION_WORDS + 1;
    endfunction

    function automatic int last_word(input int region);
        return (region + 1) * REGION_WORDS;
    endfunction

    // fifo model, word = source id on top, read index below
    always @(posedge clk)
    begin : fifo_model
        logic [NUM_SRC-1:0] strobe;
        strobe = rden;
        #2;
        if (rst_n)
        begin
            for (int k = 0; k < NUM_SRC; k++)
            begin
                if (strobe[k])
                begin
                    src_fifo[k].rddata = {4'(k), 12'(rd_cnt[k])};
                    rd_cnt[k]++;
                    if (rd_cnt[k] == REGION_WORDS)
                    begin
                        src_fifo[k].full = 1'b0;
                        rd_cnt[k]        = 0;
                        fill_wait[k]     = ($random(seed) & 63) + 1;
                    end
                end
                else if (!src_fifo[k].full)
                begin
                    if (fill_wait[k] <= 1)
                        src_fifo[k].full = 1'b1;
                    else
                        fill_wait[k]--;
                end
            end
        end
    end

    // write side checks
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            check_val("dram_wr.en", int'(dram_wr.en), int'(prev_rden != '0));
            if (rden != '0)
            begin
                check_val("rden", int'(rden), 1 << wr_src);
                if (!src_fifo[wr_src].full)
                    stop_with_failure("rden is high while the source FIFO is not full");
            end
            if (dram_wr.en)
            begin
                check_val("dram_wr.addr", int'(dram_wr.addr), first_word(wr_src) + wr_idx);
                check_val("dram_wr.data", int'(dram_wr.data), (wr_src << 12) + wr_idx);
                wr_idx++;
                if (wr_idx == REGION_WORDS)
                begin
                    wr_idx = 0;
                    wr_src = (wr_src + 1) % NUM_SRC;
                    burst_cnt++;
                end
            end
            prev_rden = rden;
        end
    end

    // read side reference model
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (vs)
                check_val("view_mode", int'(view_mode), int'(exp_mode));
            if (scan_on)
                check_val("rd_addr", int'(rd_addr), exp_rd);
            if (view_mode != mode_seen)
            begin
                exp_rd  = first_word(upper_of(view_mode));
                scan_on = 1'b1;
            end
            else if (point_done)
            begin
                if (exp_rd == last_word(lower_of(view_mode)) && act_y == ROW_LAST)
                    exp_rd = first_word(upper_of(view_mode));
                else if (exp_rd == last_word(lower_of(view_mode)) && act_y > ROW_SPLIT)
                    exp_rd = first_word(lower_of(view_mode));
                else if (exp_rd == last_word(upper_of(view_mode)) && act_y == ROW_SPLIT)
                    exp_rd = first_word(lower_of(view_mode));
                else if (exp_rd == last_word(upper_of(view_mode)) && act_y < ROW_SPLIT)
                    exp_rd = first_word(upper_of(view_mode));
                else if (de)
                    exp_rd++;
            end
            mode_seen = view_mode;
        end
    end

    task automatic run_frame(input int keys);
        vs = 1'b1;
        for (int row = 0; row <= int'(ROW_LAST); row++)
        begin
            for (int c = 0; c < ROW_CYCLES; c++)
            begin
                act_y      = row_t'(row);
                de         = 1'b1;
                point_done = 1'b1;
                key_a      = (row == 5 && c == 0) ? keys[0] : 1'b0;
                key_b      = (row == 5 && c == 0) ? keys[1] : 1'b0;
                @(posedge clk);
                #2;
            end
        end
        de         = 1'b0;
        point_done = 1'b0;
        act_y      = '0;
        vs         = 1'b0;
        if (keys[0])
            exp_mode = (exp_mode == VIEW_HSST) ? VIEW_AD : VIEW_HSST;
        else if (keys[1])
            exp_mode = (exp_mode == VIEW_TIME) ? VIEW_FREQ : VIEW_TIME;
        for (int i = 0; i < BLANK_CYCLES; i++)
        begin
            @(posedge clk);
            #2;
            if (i == 4)
            begin
                check_val("view_mode", int'(view_mode), int'(exp_mode));
                if (keys != 0)
                    check_val("rd_addr", int'(rd_addr), first_word(upper_of(exp_mode)));
            end
        end
    endtask

    initial
    begin
        int keys;
        clk        = 1'b0;
        rst_n      = 1'b0;
        key_a      = 1'b0;
        key_b      = 1'b0;
        vs         = 1'b1;
        de         = 1'b0;
        point_done = 1'b0;
        act_y      = '0;
        prev_rden  = '0;
        wr_src     = 0;
        wr_idx     = 0;
        burst_cnt  = 0;
        exp_mode   = VIEW_HSST;
        mode_seen  = VIEW_HSST;
        scan_on    = 1'b0;
        exp_rd     = 0;
        for (int k = 0; k < NUM_SRC; k++)
        begin
            src_fifo[k]  = '0;
            rd_cnt[k]    = 0;
            fill_wait[k] = ($random(seed) & 63) + 1;
        end
        repeat (10) @(posedge clk);
        check_val("rden", int'(rden), 0);
        check_val("dram_wr.en", int'(dram_wr.en), 0);
        check_val("rd_addr", int'(rd_addr), 0);
        check_val("view_mode", int'(view_mode), int'(VIEW_HSST));
        #2;
        rst_n = 1'b1;
        for (int f = 0; f < NUM_FRAMES; f++)
        begin
            keys = $random(seed) & 3;
            if (f == 0 && keys == 0)
                keys = 1;           // scan compare needs an early restart
            if (f == 1)
                keys = 3;
            if (f == 3)
                keys = 0;
            run_frame(keys);
        end
        if (burst_cnt < MIN_BURSTS)
        begin
            stop_with_failure($sformatf("only %0d write bursts completed", burst_cnt));
        end
        else
        begin
            $display("All tests passed!");
            $finish;
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_failure("watchdog expired before the tests finished");
    end

endmodule

// File: view_select.sv
`timescale 1ns/1ps

module view_select
    import disp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       key_a,
    input  logic       key_b,
    input  logic       vs,
    output view_mode_t view_mode,
    output logic       view_changed
);

    logic vs_d1;
    logic vs_d2;
    logic frame_end;
    logic pend_a;
    logic pend_b;
    logic pend_a_d1;
    logic pend_b_d1;
    logic a_fall;
    logic b_fall;

    assign frame_end = vs_d2 && !vs_d1;    // vs fell
    assign a_fall    = pend_a_d1 && !pend_a;
    assign b_fall    = pend_b_d1 && !pend_b;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vs_d1     <= 1'b0;
            vs_d2     <= 1'b0;
            pend_a    <= 1'b0;
            pend_b    <= 1'b0;
            pend_a_d1 <= 1'b0;
            pend_b_d1 <= 1'b0;
        end
        else
        begin
            vs_d1     <= vs;
            vs_d2     <= vs_d1;
            pend_a    <= frame_end ? 1'b0 : (pend_a | key_a);
            pend_b    <= frame_end ? 1'b0 : (pend_b | key_b);
            pend_a_d1 <= pend_a;
            pend_b_d1 <= pend_b;
        end
    end

    // key a has priority when both were pressed in one frame
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            view_mode    <= VIEW_HSST;
            view_changed <= 1'b0;
        end
        else
        begin
            view_changed <= a_fall | b_fall;
            if (a_fall)
            begin
                case (view_mode)
                    VIEW_HSST: view_mode <= VIEW_AD;
                    default:   view_mode <= VIEW_HSST;
                endcase
            end
            else if (b_fall)
            begin
                case (view_mode)
                    VIEW_TIME: view_mode <= VIEW_FREQ;
                    default:   view_mode <= VIEW_TIME;
                endcase
            end
        end
    end

endmodule
